// ==== bench/program_input.hex ====
// instr    memRdData irAddr   rfWrData cen wen memAddr memWrData
// memRdData counts on lw lines only
00000820 00000000 00000000 00000000 1 1 00 00000000 // add r1, r0, r0
8C020000 00000007 00000004 00000007 0 1 00 00000000 // lw r2, 0(r0)
8C030004 FFFFFFFB 00000008 FFFFFFFB 0 1 01 00000000 // lw r3, 4(r0)
8C040008 000000F5 0000000C 000000F5 0 1 02 00000000 // lw r4, 8(r0)
00432820 00000000 00000010 00000002 1 1 00 00000000 // add r5, r2, r3
00433022 00000000 00000014 0000000C 1 1 00 00000000 // sub r6, r2, r3
00443824 00000000 00000018 00000005 1 1 00 00000000 // and r7, r2, r4
00444025 00000000 0000001C 000000F7 1 1 00 00000000 // or r8, r2, r4
0062482A 00000000 00000020 00000001 1 1 00 00000000 // slt r9, r3, r2
0043502A 00000000 00000024 00000000 1 1 00 00000000 // slt r10, r2, r3
00420020 00000000 00000028 0000000E 1 1 00 00000000 // add r0, r2, r2
00025820 00000000 0000002C 00000007 1 1 00 00000000 // add r11, r0, r2
AC460019 00000000 00000030 00000000 0 0 08 0000000C // sw r6, 25(r2)
8C4C0019 0000000C 00000034 0000000C 0 1 08 00000000 // lw r12, 25(r2)
10CC0002 00000000 00000038 00000000 1 1 00 00000000 // beq r6, r12, +2
10430005 00000000 00000044 00000000 1 1 00 00000000 // beq r2, r3, +5
08000018 00000000 00000048 00000000 1 1 00 00000000 // j 0x60
0C000020 00000000 00000060 00000064 1 1 00 00000000 // jal 0x80
FFFFFFFF 00000000 00000080 00000000 1 1 00 00000000 // unknown opcode
00000000 00000000 00000084 00000000 1 1 00 00000000 // all-zero word
03E06820 00000000 00000088 00000064 1 1 00 00000000 // add r13, r31, r0
03E00008 00000000 0000008C 00000000 1 1 00 00000000 // jr r31
01257025 00000000 00000064 00000003 1 1 00 00000000 // or r14, r9, r5
00627822 00000000 00000068 FFFFFFF4 1 1 00 00000000 // sub r15, r3, r2
1000FFFF 00000000 0000006C 00000000 1 1 00 00000000 // beq r0, r0, -1
1000FFFF 00000000 0000006C 00000000 1 1 00 00000000 // beq r0, r0, -1

// ==== tb.f ====
verilog/mipsPkg.sv
verilog/ctrlIf.sv
verilog/mainDecoder.sv
verilog/aluUnit.sv
verilog/registerFile.sv
verilog/pcUnit.sv
verilog/singleCycleMips.sv
bench/tbChecker.sv
bench/tbTop.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timescale 1ns/1ps --top-module tbTop -f tb.f -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simv > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Simulation PASSED" "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1

// ==== bench/tbTop.sv ====
module tbTop import mipsPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // run setup
    // ==============================
    localparam int dmemAddrWidth = 7;
    localparam int traceLen      = 26;  // lines in the trace file
    localparam int lineWords     = 8;   // columns per trace line
    localparam int resetCycles   = 8;
    localparam int cycleLimit    = traceLen + resetCycles + 20;

    // dut ports
    logic                     Clk;
    logic                     reset;
    logic [wordWidth-1:0]     ir;
    logic [wordWidth-1:0]     memReadData;
    logic [wordWidth-1:0]     irAddr;
    logic [wordWidth-1:0]     rfWriteData;
    logic [dmemAddrWidth-1:0] memAddr;
    logic [wordWidth-1:0]     memWriteData;
    logic                     memCen;
    logic                     memWen;

    // expectations for the line now on the bus
    logic                     checkEn;
    logic [wordWidth-1:0]     expIrAddr;
    logic [wordWidth-1:0]     expWb;
    logic                     expCen;
    logic                     expWen;
    logic [dmemAddrWidth-1:0] expMemAddr;
    logic [wordWidth-1:0]     expMemWd;

    logic [wordWidth-1:0] trace [0:traceLen*lineWords-1]; // flat with 8 words per line
    int                   seed;
    int                   cycleCount = 0;
    int                   errorCount;
    int                   checkCount;

    always #10 Clk = ~Clk; // 20 ns period

    singleCycleMips #(
        .dmemAddrWidth (dmemAddrWidth)
    ) u_dut (
        .Clk          (Clk),
        .reset        (reset),
        .irAddr       (irAddr),
        .ir           (ir),
        .rfWriteData  (rfWriteData),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memCen       (memCen),
        .memWen       (memWen)
    );

    tbChecker #(
        .addrWidth (dmemAddrWidth)
    ) u_chk (
        .Clk          (Clk),
        .checkEn      (checkEn),
        .instr        (ir),
        .expIrAddr    (expIrAddr),
        .expWb        (expWb),
        .expCen       (expCen),
        .expWen       (expWen),
        .expMemAddr   (expMemAddr),
        .expMemWd     (expMemWd),
        .irAddr       (irAddr),
        .rfWriteData  (rfWriteData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memCen       (memCen),
        .memWen       (memWen),
        .errorCount   (errorCount),
        .checkCount   (checkCount)
    );

    // puts one trace line on the dut inputs and the checker
    task automatic driveLine(input int lineNo);
        int         base;
        instrWord_t word;
        base = lineNo * lineWords;
        word = trace[base];
        ir <= word;
        if (word.i.opcode == opLw) begin
            memReadData <= trace[base + 1];
        end else begin
            memReadData <= $random(seed); // junk that must never reach a register
        end
        expIrAddr  <= trace[base + 2];
        expWb      <= trace[base + 3];
        expCen     <= trace[base + 4][0];
        expWen     <= trace[base + 5][0];
        expMemAddr <= trace[base + 6][dmemAddrWidth-1:0];
        expMemWd   <= trace[base + 7];
        checkEn    <= 1'b1;
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        Clk          = 1'b0;
        seed         = 32'hfe18_ff08;
        reset       <= 1'b0;
        ir          <= '0;
        memReadData <= '0;
        checkEn     <= 1'b0;
        $readmemh("bench/program_input.hex", trace);

        repeat (resetCycles) @(posedge Clk);
        reset <= 1'b1; // line 0 goes out on the same edge
        for (int k = 0; k < traceLen; k++) begin
            driveLine(k);
            @(posedge Clk);
        end
        checkEn <= 1'b0;
        @(negedge Clk); // last compare done by now

        $display("checks: %0d  errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // guard against a stuck run
    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run did not end within %0d cycles", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

// ==== bench/tbChecker.sv ====
module tbChecker import mipsPkg::*; #(
    parameter int addrWidth = 7
) (
    input  logic                 Clk,
    input  logic                 checkEn,
    input  instrWord_t           instr,
    input  logic [wordWidth-1:0] expIrAddr,
    input  logic [wordWidth-1:0] expWb,
    input  logic                 expCen,
    input  logic                 expWen,
    input  logic [addrWidth-1:0] expMemAddr,
    input  logic [wordWidth-1:0] expMemWd,
    input  logic [wordWidth-1:0] irAddr,
    input  logic [wordWidth-1:0] rfWriteData,
    input  logic [addrWidth-1:0] memAddr,
    input  logic [wordWidth-1:0] memWriteData,
    input  logic                 memCen,
    input  logic                 memWen,
    output int                   errorCount,
    output int                   checkCount
);

    timeunit 1ns;
    timeprecision 1ps;

    int errors = 0;
    int checks = 0;
    int lineNo = 0; // trace line under check

    assign errorCount = errors;
    assign checkCount = checks;

    // r-type alu ops, lw and jal write back
    function automatic logic writesRegister(input instrWord_t w);
        case (w.r.opcode)
            opRType:     return w.r.funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt};
            opLw, opJal: return 1'b1;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [wordWidth-1:0] expVal,
                                input logic [wordWidth-1:0] actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("Error: %s expected 0x%h, got 0x%h (trace line %0d)",
                     name, expVal, actVal, lineNo);
        end
    endtask

    // ==============================
    // compare mid-cycle once outputs have settled
    // ==============================
    always @(negedge Clk) begin
        if (checkEn) begin
            compareValue("irAddr", expIrAddr, irAddr);
            compareValue("memCen", {31'd0, expCen}, {31'd0, memCen});
            compareValue("memWen", {31'd0, expWen}, {31'd0, memWen});
            if (!expCen) begin // address and data only matter on access
                compareValue("memAddr", 32'(expMemAddr), 32'(memAddr));
                compareValue("memWriteData", expMemWd, memWriteData);
            end
            if (writesRegister(instr)) begin
                compareValue("rfWriteData", expWb, rfWriteData);
            end
            lineNo++;
        end
    end

endmodule

// ==== verilog/singleCycleMips.sv ====
module singleCycleMips import mipsPkg::*; #(
    parameter int dmemAddrWidth = 7
) (
    input  logic                     Clk,
    input  logic                     reset,
    output logic [wordWidth-1:0]     irAddr,
    input  logic [wordWidth-1:0]     ir,
    output logic [wordWidth-1:0]     rfWriteData,
    input  logic [wordWidth-1:0]     memReadData,
    output logic [dmemAddrWidth-1:0] memAddr,
    output logic [wordWidth-1:0]     memWriteData,
    output logic                     memCen,
    output logic                     memWen
);

    instrWord_t              instr;
    logic [wordWidth-1:0]    signExt;
    logic [wordWidth-1:0]    readDataA;
    logic [wordWidth-1:0]    readDataB;
    logic [wordWidth-1:0]    aluB;
    logic [wordWidth-1:0]    aluResult;
    logic                    zero;
    logic [wordWidth-1:0]    pc;
    logic [wordWidth-1:0]    pcPlus4;
    logic [regAddrWidth-1:0] writeReg;
    logic [wordWidth-1:0]    wbData;

    ctrlIf ctrl ();

    assign instr   = ir;
    assign signExt = {{16{instr.i.imm16[15]}}, instr.i.imm16};

    // ==============================
    // blocks
    // ==============================
    mainDecoder u_dec (
        .opcode (instr.r.opcode),
        .funct  (instr.r.funct),
        .ctrl   (ctrl)
    );

    registerFile u_rf (
        .Clk       (Clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .writeAddr (writeReg),
        .writeData (wbData),
        .readAddrA (instr.r.rs),
        .readAddrB (instr.r.rt),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    aluUnit u_alu (
        .ctrl   (ctrl),
        .funct  (instr.r.funct),
        .a      (readDataA),
        .b      (aluB),
        .result (aluResult),
        .zero   (zero)
    );

    pcUnit u_pc (
        .Clk          (Clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .instr        (instr),
        .zero         (zero),
        .jumpRegValue (readDataA), // rs for jr
        .pc           (pc),
        .pcPlus4      (pcPlus4)
    );

    // ==============================
    // datapath muxes
    // ==============================
    assign aluB = ctrl.aluSrc ? signExt : readDataB;

    always_comb begin
        case (ctrl.regDst)
            regDstRd: writeReg = instr.r.rd;
            regDstRa: writeReg = linkReg;
            default:  writeReg = instr.r.rt; // regDstRt
        endcase
    end

    always_comb begin
        case (ctrl.memToReg)
            wbMem:   wbData = memReadData;
            wbLink:  wbData = pcPlus4;
            default: wbData = aluResult;     // wbAlu
        endcase
    end

    // sram side is word addressed with active-low enables
    assign memAddr      = aluResult[dmemAddrWidth+1:2];
    assign memWriteData = readDataB;
    assign memCen       = ~(ctrl.memRead | ctrl.memWrite);
    assign memWen       = ~ctrl.memWrite;

    assign irAddr      = pc;
    assign rfWriteData = wbData;

endmodule

// ==== verilog/pcUnit.sv ====
module pcUnit import mipsPkg::*; (
    input  logic                  Clk,
    input  logic                  reset,
    ctrlIf.pc                     ctrl,
    input  instrWord_t            instr,
    input  logic                  zero,
    input  logic [wordWidth-1:0]  jumpRegValue,
    output logic [wordWidth-1:0]  pc,
    output logic [wordWidth-1:0]  pcPlus4
);

    logic [wordWidth-1:0] branchAddr;
    logic [wordWidth-1:0] jumpAddr;
    logic [wordWidth-1:0] nextPc;
    logic                 takeBranch;

    assign pcPlus4 = pc + 32'd4;

    // word offset sign-extended and scaled to bytes
    assign branchAddr = pcPlus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
    assign jumpAddr   = {pcPlus4[31:28], instr.j.target26, 2'b00}; // stays in 256 MB region

    assign takeBranch = ctrl.branch & zero;

    // ==============================
    // next pc select
    // ==============================
    always_comb begin
        case (ctrl.jump)
            jumpTarget: nextPc = jumpAddr;
            jumpReg:    nextPc = jumpRegValue; // rs value for jr
            jumpNone:   nextPc = takeBranch ? branchAddr : pcPlus4;
            default:    nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc; // one instruction per edge
        end
    end

endmodule

// ==== verilog/registerFile.sv ====
module registerFile import mipsPkg::*; (
    input  logic                    Clk,
    input  logic                    reset,
    ctrlIf.regs                     ctrl,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [wordWidth-1:0]    writeData,
    input  logic [regAddrWidth-1:0] readAddrA,
    input  logic [regAddrWidth-1:0] readAddrB,
    output logic [wordWidth-1:0]    readDataA,
    output logic [wordWidth-1:0]    readDataB
);

    logic [wordWidth-1:0] regs [1:31]; // r0 has no storage

    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && writeAddr != '0) begin
            regs[writeAddr] <= writeData; // writes to r0 dropped
        end
    end

    // combinational reads show the old value until the edge
    always_comb begin
        if (readAddrA == '0) begin
            readDataA = '0;
        end else begin
            readDataA = regs[readAddrA];
        end
    end

    always_comb begin
        if (readAddrB == '0) begin
            readDataB = '0;
        end else begin
            readDataB = regs[readAddrB];
        end
    end

endmodule

// ==== verilog/aluUnit.sv ====
module aluUnit import mipsPkg::*; (
    ctrlIf.alu                     ctrl,
    input  logic [5:0]             funct,
    input  logic [wordWidth-1:0]   a,
    input  logic [wordWidth-1:0]   b,
    output logic [wordWidth-1:0]   result,
    output logic                   zero
);

    logic [3:0]           aluCtrl;
    logic [wordWidth-1:0] diff;

    // ==============================
    // alu control
    // ==============================
    always_comb begin
        case (ctrl.aluOp)
            aluOpSub: aluCtrl = aluSub;
            aluOpFunct: begin
                case (funct)
                    fnSub:   aluCtrl = aluSub;
                    fnAnd:   aluCtrl = aluAnd;
                    fnOr:    aluCtrl = aluOr;
                    fnSlt:   aluCtrl = aluSlt;
                    default: aluCtrl = aluAdd; // fnAdd and anything unknown
                endcase
            end
            default: aluCtrl = aluAdd;
        endcase
    end

    // ==============================
    // datapath
    // ==============================
    assign diff = a - b; // shared by sub and the zero flag
    assign zero = (diff == '0);

    always_comb begin
        case (aluCtrl)
            aluSub: result = diff;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluSlt: result = {{(wordWidth-1){1'b0}}, $signed(a) < $signed(b)}; // signed compare
            default: result = a + b;
        endcase
    end

endmodule

// ==== verilog/mainDecoder.sv ====
module mainDecoder import mipsPkg::*; (
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    ctrlIf.decoder     ctrl
);

    always_comb begin
        // all-inactive pattern so unknown words fall through as a no-op
        ctrl.regDst   = regDstRt;
        ctrl.aluSrc   = 1'b0;
        ctrl.memToReg = wbAlu;
        ctrl.regWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = aluOpAdd;
        ctrl.jump     = jumpNone;

        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt: begin
                        ctrl.regDst   = regDstRd;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluOpFunct;
                    end
                    fnJr: ctrl.jump = jumpReg; // no write back for jr
                    default: ;
                endcase
            end
            opLw: begin
                ctrl.aluSrc   = 1'b1;      // base + offset
                ctrl.memToReg = wbMem;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluOpSub;    // zero flag does the compare
            end
            opJ: ctrl.jump = jumpTarget;
            opJal: begin
                ctrl.regDst   = regDstRa;
                ctrl.memToReg = wbLink;
                ctrl.regWrite = 1'b1;
                ctrl.jump     = jumpTarget;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/ctrlIf.sv ====
interface ctrlIf;

    logic [1:0] regDst;   // rt / rd / ra
    logic       aluSrc;   // 1 = sign-extended imm16
    logic [1:0] memToReg; // write-back source
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       branch;
    logic [1:0] aluOp;
    logic [1:0] jump;     // none / target / register

    modport decoder (
        output regDst, aluSrc, memToReg, regWrite, memRead, memWrite, branch, aluOp, jump
    );

    modport datapath (input regDst, aluSrc, memToReg, memRead, memWrite);

    modport alu (input aluOp);

    modport pc (input branch, jump);

    modport regs (input regWrite);

endinterface

// ==== verilog/mipsPkg.sv ====
package mipsPkg;

    // ==============================
    // widths
    // ==============================
    localparam int wordWidth    = 32;
    localparam int regAddrWidth = 5;

    localparam logic [regAddrWidth-1:0] linkReg = 5'd31; // jal return address lands here

    // ==============================
    // opcodes and funct codes
    // ==============================
    localparam logic [5:0] opRType = 6'b000000;
    localparam logic [5:0] opLw    = 6'b100011;
    localparam logic [5:0] opSw    = 6'b101011;
    localparam logic [5:0] opBeq   = 6'b000100;
    localparam logic [5:0] opJ     = 6'b000010;
    localparam logic [5:0] opJal   = 6'b000011;

    localparam logic [5:0] fnAdd = 6'b100000;
    localparam logic [5:0] fnSub = 6'b100010;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr  = 6'b100101;
    localparam logic [5:0] fnSlt = 6'b101010;
    localparam logic [5:0] fnJr  = 6'b001000;

    // ==============================
    // alu op from main decoder and alu control code
    // ==============================
    localparam logic [1:0] aluOpAdd   = 2'b00; // lw / sw address
    localparam logic [1:0] aluOpSub   = 2'b01; // beq compare
    localparam logic [1:0] aluOpFunct = 2'b10; // r-type looks at funct

    localparam logic [3:0] aluAnd = 4'b0000;
    localparam logic [3:0] aluOr  = 4'b0001;
    localparam logic [3:0] aluAdd = 4'b0010;
    localparam logic [3:0] aluSub = 4'b0110;
    localparam logic [3:0] aluSlt = 4'b0111;

    // ==============================
    // mux selects
    // ==============================
    localparam logic [1:0] regDstRt = 2'b00;
    localparam logic [1:0] regDstRd = 2'b01;
    localparam logic [1:0] regDstRa = 2'b10;

    localparam logic [1:0] wbAlu  = 2'b00;
    localparam logic [1:0] wbMem  = 2'b01;
    localparam logic [1:0] wbLink = 2'b10; // pc + 4 for jal

    localparam logic [1:0] jumpNone   = 2'b00;
    localparam logic [1:0] jumpTarget = 2'b01;
    localparam logic [1:0] jumpReg    = 2'b10;

    // one instruction word with three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } instrWord_t;

endpackage
